// ==== rtl/rs_pkg.sv ====
package rs_pkg;

  // Reorder-buffer tag and operand widths
  localparam int TAG_W = 4;
  localparam int DATA_W = 32;

  // Entries per reservation station
  localparam int RS_DEPTH = 4;
  localparam int RS_IDX_W = 2;

  // Opcodes seen by the issue stage
  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_OR    = 3'd3,
    OP_LOAD  = 3'd4,
    OP_STORE = 3'd5
  } rs_op_e;

  // Source operand, either a value or the tag it waits for
  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] value;
  } rs_operand_t;

  // One station slot
  typedef struct packed {
    logic             busy;
    rs_op_e           op;
    rs_operand_t      a;
    rs_operand_t      b;
    logic [TAG_W-1:0] dst_tag;
  } rs_entry_t;

  // Load and store go to the load/store station
  function automatic logic is_mem_op(rs_op_e op);
    return (op == OP_LOAD) || (op == OP_STORE);
  endfunction

endpackage

// ==== rtl/rs_dispatch_if.sv ====
`timescale 1ns/1ps

interface rs_dispatch_if
  import rs_pkg::*;
();

  logic             valid;
  logic             ready;
  rs_op_e           op;
  rs_operand_t      a;
  rs_operand_t      b;
  logic [TAG_W-1:0] dst_tag;

  // Router side
  modport src (
    output valid, op, a, b, dst_tag,
    input  ready
  );

  // Station side
  modport dst (
    input  valid, op, a, b, dst_tag,
    output ready
  );

endinterface

// ==== rtl/rs_issue_if.sv ====
`timescale 1ns/1ps

interface rs_issue_if
  import rs_pkg::*;
();

  logic              valid;
  logic              ready;
  rs_op_e            op;
  logic [DATA_W-1:0] a_value;
  logic [DATA_W-1:0] b_value;
  logic [TAG_W-1:0]  dst_tag;

  // Station offers, arbiter grants
  modport src (
    output valid, op, a_value, b_value, dst_tag,
    input  ready
  );

  modport dst (
    input  valid, op, a_value, b_value, dst_tag,
    output ready
  );

endinterface

// ==== rtl/dispatch_router.sv ====
`timescale 1ns/1ps

module dispatch_router
  import rs_pkg::*;
(
  input  logic              dispatch_valid,
  input  rs_op_e            dispatch_op,
  input  logic              dispatch_a_valid,
  input  logic [TAG_W-1:0]  dispatch_a_tag,
  input  logic [DATA_W-1:0] dispatch_a_value,
  input  logic              dispatch_b_valid,
  input  logic [TAG_W-1:0]  dispatch_b_tag,
  input  logic [DATA_W-1:0] dispatch_b_value,
  input  logic [TAG_W-1:0]  dispatch_dst_tag,
  output logic              dispatch_ready,
  rs_dispatch_if.src        alu_port,
  rs_dispatch_if.src        ls_port
);

  logic        mem_class;
  rs_operand_t opnd_a;
  rs_operand_t opnd_b;

  assign mem_class = is_mem_op(dispatch_op);
  assign opnd_a = '{valid: dispatch_a_valid, tag: dispatch_a_tag, value: dispatch_a_value};
  assign opnd_b = '{valid: dispatch_b_valid, tag: dispatch_b_tag, value: dispatch_b_value};

  // Only the station of the opcode class sees valid
  assign alu_port.valid   = dispatch_valid & ~mem_class;
  assign alu_port.op      = dispatch_op;
  assign alu_port.a       = opnd_a;
  assign alu_port.b       = opnd_b;
  assign alu_port.dst_tag = dispatch_dst_tag;

  assign ls_port.valid   = dispatch_valid & mem_class;
  assign ls_port.op      = dispatch_op;
  assign ls_port.a       = opnd_a;
  assign ls_port.b       = opnd_b;
  assign ls_port.dst_tag = dispatch_dst_tag;

  assign dispatch_ready = mem_class ? ls_port.ready : alu_port.ready;

endmodule

// ==== rtl/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station
  import rs_pkg::*;
(
  input  logic              in_clk,
  input  logic              in_rst_n,
  input  logic              flush,
  rs_dispatch_if.dst        disp,
  input  logic              cdb_valid,
  input  logic [TAG_W-1:0]  cdb_tag,
  input  logic [DATA_W-1:0] cdb_value,
  rs_issue_if.src           issue
);

  rs_entry_t            entries [RS_DEPTH];
  logic [RS_IDX_W-1:0]  free_idx;
  logic                 has_free;
  logic [RS_IDX_W-1:0]  ready_idx;
  logic                 has_ready;
  logic                 accept;
  logic                 grant;

  // Picks up a broadcast value for an operand still waiting on its tag
  function automatic rs_operand_t snoop_cdb(rs_operand_t opnd);
    rs_operand_t res;
    res = opnd;
    if (cdb_valid && !opnd.valid && (opnd.tag == cdb_tag)) begin
      res.valid = 1'b1;
      res.value = cdb_value;
    end
    return res;
  endfunction

  // Lowest free slot
  always_comb begin
    free_idx = '0;
    has_free = 1'b0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (!entries[i].busy) begin
        free_idx = RS_IDX_W'(i);
        has_free = 1'b1;
      end
    end
  end

  // Lowest slot with both operands present
  always_comb begin
    ready_idx = '0;
    has_ready = 1'b0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (entries[i].busy && entries[i].a.valid && entries[i].b.valid) begin
        ready_idx = RS_IDX_W'(i);
        has_ready = 1'b1;
      end
    end
  end

  // No new entry is taken in a flush cycle
  assign disp.ready = has_free & ~flush;
  assign accept     = disp.valid & disp.ready;

  // Issue offer straight from the selected slot
  assign issue.valid   = has_ready;
  assign issue.op      = entries[ready_idx].op;
  assign issue.a_value = entries[ready_idx].a.value;
  assign issue.b_value = entries[ready_idx].b.value;
  assign issue.dst_tag = entries[ready_idx].dst_tag;
  assign grant         = issue.valid & issue.ready;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        entries[i] <= '0;
      end
    end else if (flush) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        entries[i].busy <= 1'b0;
      end
    end else begin
      // Wakeup of waiting operands
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (entries[i].busy) begin
          entries[i].a <= snoop_cdb(entries[i].a);
          entries[i].b <= snoop_cdb(entries[i].b);
        end
      end
      if (grant) begin
        entries[ready_idx].busy <= 1'b0;
      end
      // Free slot is never the granted one, so both can happen together
      if (accept) begin
        entries[free_idx] <= '{
          busy:    1'b1,
          op:      disp.op,
          a:       snoop_cdb(disp.a),
          b:       snoop_cdb(disp.b),
          dst_tag: disp.dst_tag
        };
      end
    end
  end

endmodule

// ==== rtl/issue_arbiter.sv ====
`timescale 1ns/1ps

module issue_arbiter
  import rs_pkg::*;
(
  input  logic              in_clk,
  input  logic              in_rst_n,
  input  logic              flush,
  rs_issue_if.dst           alu,
  rs_issue_if.dst           ls,
  output logic              issue_valid,
  output rs_op_e            issue_op,
  output logic [DATA_W-1:0] issue_a,
  output logic [DATA_W-1:0] issue_b,
  output logic [TAG_W-1:0]  issue_dst_tag,
  input  logic              issue_ready
);

  logic can_load;

  // Output stage is empty or drains this cycle
  assign can_load = ~issue_valid | issue_ready;

  // Load/store first, ALU stalls while load/store offers
  assign ls.ready  = can_load & ~flush;
  assign alu.ready = can_load & ~flush & ~ls.valid;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      issue_valid <= 1'b0;
    end else if (flush) begin
      issue_valid <= 1'b0;
    end else if (can_load) begin
      issue_valid <= ls.valid | alu.valid;
    end
  end

  always_ff @(posedge in_clk) begin
    if (ls.valid && ls.ready) begin
      issue_op      <= ls.op;
      issue_a       <= ls.a_value;
      issue_b       <= ls.b_value;
      issue_dst_tag <= ls.dst_tag;
    end else if (alu.valid && alu.ready) begin
      issue_op      <= alu.op;
      issue_a       <= alu.a_value;
      issue_b       <= alu.b_value;
      issue_dst_tag <= alu.dst_tag;
    end
  end

endmodule

// ==== rtl/rs_top.sv ====
`timescale 1ns/1ps

module rs_top
  import rs_pkg::*;
(
  input  logic              in_clk,
  input  logic              in_rst_n,
  input  logic              flush,
  input  logic              dispatch_valid,
  input  rs_op_e            dispatch_op,
  input  logic              dispatch_a_valid,
  input  logic [TAG_W-1:0]  dispatch_a_tag,
  input  logic [DATA_W-1:0] dispatch_a_value,
  input  logic              dispatch_b_valid,
  input  logic [TAG_W-1:0]  dispatch_b_tag,
  input  logic [DATA_W-1:0] dispatch_b_value,
  input  logic [TAG_W-1:0]  dispatch_dst_tag,
  output logic              dispatch_ready,
  input  logic              cdb_valid,
  input  logic [TAG_W-1:0]  cdb_tag,
  input  logic [DATA_W-1:0] cdb_value,
  output logic              issue_valid,
  output rs_op_e            issue_op,
  output logic [DATA_W-1:0] issue_a,
  output logic [DATA_W-1:0] issue_b,
  output logic [TAG_W-1:0]  issue_dst_tag,
  input  logic              issue_ready
);

  rs_dispatch_if alu_disp ();
  rs_dispatch_if ls_disp ();
  rs_issue_if    alu_issue ();
  rs_issue_if    ls_issue ();

  dispatch_router i_dispatch_router (
    .dispatch_valid   (dispatch_valid),
    .dispatch_op      (dispatch_op),
    .dispatch_a_valid (dispatch_a_valid),
    .dispatch_a_tag   (dispatch_a_tag),
    .dispatch_a_value (dispatch_a_value),
    .dispatch_b_valid (dispatch_b_valid),
    .dispatch_b_tag   (dispatch_b_tag),
    .dispatch_b_value (dispatch_b_value),
    .dispatch_dst_tag (dispatch_dst_tag),
    .dispatch_ready   (dispatch_ready),
    .alu_port         (alu_disp),
    .ls_port          (ls_disp)
  );

  // Both stations snoop the same CDB
  reservation_station alu_station (
    .in_clk    (in_clk),
    .in_rst_n  (in_rst_n),
    .flush     (flush),
    .disp      (alu_disp),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value),
    .issue     (alu_issue)
  );

  reservation_station ls_station (
    .in_clk    (in_clk),
    .in_rst_n  (in_rst_n),
    .flush     (flush),
    .disp      (ls_disp),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value),
    .issue     (ls_issue)
  );

  issue_arbiter i_issue_arbiter (
    .in_clk        (in_clk),
    .in_rst_n      (in_rst_n),
    .flush         (flush),
    .alu           (alu_issue),
    .ls            (ls_issue),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_a       (issue_a),
    .issue_b       (issue_b),
    .issue_dst_tag (issue_dst_tag),
    .issue_ready   (issue_ready)
  );

endmodule

// ==== verification/rs_chk.sv ====
`timescale 1ns/1ps

module rs_chk
  import rs_pkg::*;
(
  input logic              in_clk,
  input logic              in_rst_n,
  input logic              flush,
  input logic              dispatch_ready,
  input logic              issue_valid,
  input rs_op_e            issue_op,
  input logic [DATA_W-1:0] issue_a,
  input logic [DATA_W-1:0] issue_b,
  input logic [TAG_W-1:0]  issue_dst_tag,
  input logic              issue_ready
);

  int fail_count = 0;

  // Stalled output stage keeps its contents
  assert property (@(posedge in_clk) disable iff (!in_rst_n)
    issue_valid && !issue_ready && !flush |=>
      issue_valid && $stable(issue_op) && $stable(issue_a) && $stable(issue_b) &&
      $stable(issue_dst_tag))
  else begin
    fail_count++;
    $error("issue outputs changed while issue_ready was low");
  end

  // Flush empties the output register
  assert property (@(posedge in_clk) disable iff (!in_rst_n) flush |=> !issue_valid)
  else begin
    fail_count++;
    $error("issue_valid high in the cycle after flush");
  end

  // Empty stations accept right after reset
  assert property (@(posedge in_clk) $rose(in_rst_n) |-> dispatch_ready)
  else begin
    fail_count++;
    $error("dispatch_ready low after reset");
  end

  assert property (@(posedge in_clk) disable iff (!in_rst_n) !$isunknown(issue_valid))
  else begin
    fail_count++;
    $error("issue_valid is unknown");
  end

endmodule

// ==== verification/rs_tb.sv ====
`timescale 1ns/1ps

module rs_tb
  import rs_pkg::*;
();

  logic              in_clk;
  logic              in_rst_n;
  logic              flush;
  logic              dispatch_valid;
  rs_op_e            dispatch_op;
  logic              dispatch_a_valid;
  logic [TAG_W-1:0]  dispatch_a_tag;
  logic [DATA_W-1:0] dispatch_a_value;
  logic              dispatch_b_valid;
  logic [TAG_W-1:0]  dispatch_b_tag;
  logic [DATA_W-1:0] dispatch_b_value;
  logic [TAG_W-1:0]  dispatch_dst_tag;
  logic              dispatch_ready;
  logic              cdb_valid;
  logic [TAG_W-1:0]  cdb_tag;
  logic [DATA_W-1:0] cdb_value;
  logic              issue_valid;
  rs_op_e            issue_op;
  logic [DATA_W-1:0] issue_a;
  logic [DATA_W-1:0] issue_b;
  logic [TAG_W-1:0]  issue_dst_tag;
  logic              issue_ready;

  // Stimulus side state
  logic [31:0] rng_state;
  int          tests_run;
  int          stim_errors;
  logic        prio_armed;
  int          prio_base;
  int          test_len [5] = '{8, 4, 5, 8, 6};

  // Scoreboard, indexed by destination tag
  logic        sb_live [2**TAG_W];
  logic        sb_done [2**TAG_W];
  rs_op_e      sb_op   [2**TAG_W];
  rs_operand_t sb_a    [2**TAG_W];
  rs_operand_t sb_b    [2**TAG_W];
  int          outstanding;
  int          issued;
  int          errors;

  rs_top i_rs_top (.*);

  bind rs_top rs_chk i_rs_chk (
    .in_clk         (in_clk),
    .in_rst_n       (in_rst_n),
    .flush          (flush),
    .dispatch_ready (dispatch_ready),
    .issue_valid    (issue_valid),
    .issue_op       (issue_op),
    .issue_a        (issue_a),
    .issue_b        (issue_b),
    .issue_dst_tag  (issue_dst_tag),
    .issue_ready    (issue_ready)
  );

  initial begin
    in_clk = 1'b0;
    forever #4 in_clk = ~in_clk;
  end

  function automatic logic [31:0] xorshift32();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic rs_op_e rand_op(input logic mem);
    logic [31:0] r;
    r = xorshift32();
    if (mem) begin
      return r[0] ? OP_STORE : OP_LOAD;
    end
    return rs_op_e'({1'b0, r[1:0]});
  endfunction

  task automatic present(input rs_op_e op, input logic a_wait, input logic [TAG_W-1:0] a_tag,
                         input logic b_wait, input logic [TAG_W-1:0] b_tag,
                         input logic [TAG_W-1:0] dst);
    dispatch_valid   <= 1'b1;
    dispatch_op      <= op;
    dispatch_a_valid <= !a_wait;
    dispatch_a_tag   <= a_tag;
    dispatch_a_value <= xorshift32();
    dispatch_b_valid <= !b_wait;
    dispatch_b_tag   <= b_tag;
    dispatch_b_value <= xorshift32();
    dispatch_dst_tag <= dst;
  endtask

  // Holds the instruction until the station takes it
  task automatic send(input rs_op_e op, input logic a_wait, input logic [TAG_W-1:0] a_tag,
                      input logic b_wait, input logic [TAG_W-1:0] b_tag,
                      input logic [TAG_W-1:0] dst);
    present(op, a_wait, a_tag, b_wait, b_tag, dst);
    @(posedge in_clk);
    while (!dispatch_ready) @(posedge in_clk);
  endtask

  task automatic broadcast(input logic [TAG_W-1:0] tag);
    cdb_valid <= 1'b1;
    cdb_tag   <= tag;
    cdb_value <= xorshift32();
    @(posedge in_clk);
    cdb_valid <= 1'b0;
  endtask

  task automatic drain(input logic toggle);
    logic [31:0] r;
    do begin
      r = xorshift32();
      issue_ready <= toggle ? r[0] : 1'b1;
      @(posedge in_clk);
    end while (outstanding != 0);
    issue_ready <= 1'b1;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("[%0t] test %0d %s done, %0d issued, %0d errors so far", $time, tests_run, name,
             issued, errors + stim_errors);
  endtask

  task automatic check_issue();
    logic [TAG_W-1:0] t;
    t = issue_dst_tag;
    assert (sb_live[t]) else begin
      errors++;
      if (sb_done[t]) begin
        $display("[%0t] tag %0d issued a second time", $time, t);
      end else begin
        $display("[%0t] tag %0d issued with no instruction in flight", $time, t);
      end
    end
    if (sb_live[t]) begin
      assert (sb_a[t].valid && sb_b[t].valid) else begin
        errors++;
        $display("[%0t] tag %0d issued before its operands were broadcast", $time, t);
      end
      assert (issue_op == sb_op[t]) else begin
        errors++;
        $display("MISMATCH time=%0t issue_op got=%s expected=%s", $time, issue_op.name(),
                 sb_op[t].name());
      end
      assert (issue_a == sb_a[t].value) else begin
        errors++;
        $display("MISMATCH time=%0t issue_a got=%h expected=%h", $time, issue_a, sb_a[t].value);
      end
      assert (issue_b == sb_b[t].value) else begin
        errors++;
        $display("MISMATCH time=%0t issue_b got=%h expected=%h", $time, issue_b, sb_b[t].value);
      end
      // Load/store ahead of waiting ALU work
      if (prio_armed && issued < prio_base + 4) begin
        assert (is_mem_op(issue_op)) else begin
          errors++;
          $display("[%0t] ALU tag %0d issued while load/store work was ready", $time, t);
        end
      end
      sb_live[t] = 1'b0;
      sb_done[t] = 1'b1;
      outstanding--;
      issued++;
    end
  endtask

  // Monitor and scoreboard
  always @(posedge in_clk) begin
    if (!in_rst_n) begin
      foreach (sb_live[t]) begin
        sb_live[t] = 1'b0;
        sb_done[t] = 1'b0;
      end
      outstanding = 0;
      issued      = 0;
      errors      = 0;
    end else begin
      if (issue_valid && issue_ready) check_issue();
      if (flush) begin
        foreach (sb_live[t]) begin
          if (sb_live[t]) outstanding--;
          sb_live[t] = 1'b0;
        end
      end else begin
        if (dispatch_valid && dispatch_ready) begin
          sb_live[dispatch_dst_tag] = 1'b1;
          sb_done[dispatch_dst_tag] = 1'b0;
          sb_op[dispatch_dst_tag]   = dispatch_op;
          sb_a[dispatch_dst_tag]    = '{dispatch_a_valid, dispatch_a_tag, dispatch_a_value};
          sb_b[dispatch_dst_tag]    = '{dispatch_b_valid, dispatch_b_tag, dispatch_b_value};
          outstanding++;
        end
        // Broadcast reaches new and waiting operands alike
        if (cdb_valid) begin
          foreach (sb_live[t]) begin
            if (sb_live[t] && !sb_a[t].valid && sb_a[t].tag == cdb_tag) begin
              sb_a[t].valid = 1'b1;
              sb_a[t].value = cdb_value;
            end
            if (sb_live[t] && !sb_b[t].valid && sb_b[t].tag == cdb_tag) begin
              sb_b[t].valid = 1'b1;
              sb_b[t].value = cdb_value;
            end
          end
        end
      end
    end
  end

  // 20 cycles allowed per instruction
  initial begin
    int budget;
    budget = 20;
    foreach (test_len[i]) budget += test_len[i] * 20;
    repeat (budget) @(posedge in_clk);
    $display("watchdog expired after %0d cycles, a test did not complete", budget);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    int          total;
    rng_state        = 32'hc2d413f6;
    tests_run        = 0;
    stim_errors      = 0;
    prio_armed       = 1'b0;
    prio_base        = 0;
    in_rst_n         = 1'b0;
    flush            = 1'b0;
    dispatch_valid   = 1'b0;
    dispatch_op      = OP_ADD;
    dispatch_a_valid = 1'b0;
    dispatch_a_tag   = '0;
    dispatch_a_value = '0;
    dispatch_b_valid = 1'b0;
    dispatch_b_tag   = '0;
    dispatch_b_value = '0;
    dispatch_dst_tag = '0;
    cdb_valid        = 1'b0;
    cdb_tag          = '0;
    cdb_value        = '0;
    issue_ready      = 1'b0;
    repeat (4) @(posedge in_clk);
    in_rst_n <= 1'b1;
    @(posedge in_clk);

    issue_ready <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      r = xorshift32();
      send(rand_op(r[3]), 1'b0, 4'd0, 1'b0, 4'd0, TAG_W'(i));
    end
    dispatch_valid <= 1'b0;
    drain(1'b0);
    end_test("ready operands");

    // Producers 8 to 11 are broadcast later
    send(rand_op(1'b0), 1'b1, 4'd8, 1'b0, 4'd0, 4'd0);
    send(rand_op(1'b1), 1'b1, 4'd9, 1'b1, 4'd10, 4'd1);
    send(rand_op(1'b0), 1'b0, 4'd0, 1'b1, 4'd9, 4'd2);
    dispatch_valid <= 1'b0;
    repeat (4) @(posedge in_clk);
    broadcast(4'd8);
    broadcast(4'd9);
    broadcast(4'd10);
    // Tag 11 on the CDB in the dispatch cycle itself
    cdb_valid <= 1'b1;
    cdb_tag   <= 4'd11;
    cdb_value <= xorshift32();
    send(OP_SUB, 1'b1, 4'd11, 1'b1, 4'd11, 4'd3);
    cdb_valid      <= 1'b0;
    dispatch_valid <= 1'b0;
    drain(1'b0);
    end_test("wakeup");

    issue_ready <= 1'b0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      send(rand_op(1'b0), 1'b1, 4'd12, 1'b0, 4'd0, TAG_W'(i));
    end
    present(OP_ADD, 1'b0, 4'd0, 1'b0, 4'd0, 4'd4);
    @(posedge in_clk);
    assert (!dispatch_ready) else begin
      stim_errors++;
      $display("MISMATCH time=%0t dispatch_ready got=1 expected=0", $time);
    end
    send(OP_LOAD, 1'b0, 4'd0, 1'b0, 4'd0, 4'd5);
    dispatch_valid <= 1'b0;
    broadcast(4'd12);
    drain(1'b0);
    end_test("full station");

    issue_ready <= 1'b0;
    prio_base  = issued;
    prio_armed = 1'b1;
    for (int i = 0; i < 4; i++) begin
      send(rand_op(1'b1), 1'b0, 4'd0, 1'b0, 4'd0, TAG_W'(i));
    end
    for (int i = 4; i < 8; i++) begin
      send(rand_op(1'b0), 1'b0, 4'd0, 1'b0, 4'd0, TAG_W'(i));
    end
    dispatch_valid <= 1'b0;
    drain(1'b1);
    prio_armed = 1'b0;
    end_test("back-pressure and priority");

    issue_ready <= 1'b0;
    send(rand_op(1'b0), 1'b1, 4'd13, 1'b0, 4'd0, 4'd0);
    send(rand_op(1'b1), 1'b1, 4'd13, 1'b0, 4'd0, 4'd1);
    send(rand_op(1'b0), 1'b0, 4'd0, 1'b0, 4'd0, 4'd2);
    // Ready ALU entry moves into the stalled output register
    dispatch_valid <= 1'b0;
    @(posedge in_clk);
    // Dispatch in the flush cycle is dropped
    present(OP_ADD, 1'b0, 4'd0, 1'b0, 4'd0, 4'd3);
    flush <= 1'b1;
    @(posedge in_clk);
    flush          <= 1'b0;
    dispatch_valid <= 1'b0;
    issue_ready    <= 1'b1;
    broadcast(4'd13);
    repeat (6) @(posedge in_clk);
    for (int i = 4; i < 7; i++) begin
      r = xorshift32();
      send(rand_op(r[5]), 1'b0, 4'd0, 1'b0, 4'd0, TAG_W'(i));
    end
    dispatch_valid <= 1'b0;
    drain(1'b0);
    end_test("flush");

    total = errors + stim_errors + i_rs_top.i_rs_chk.fail_count;
    $display("tests run: %0d, instructions issued: %0d, errors: %0d", tests_run, issued, total);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
rtl/rs_pkg.sv
rtl/rs_dispatch_if.sv
rtl/rs_issue_if.sv
rtl/dispatch_router.sv
rtl/reservation_station.sv
rtl/issue_arbiter.sv
rtl/rs_top.sv
verification/rs_chk.sv
verification/rs_tb.sv

// ==== Makefile ====
SIM  = obj_dir/Vrs_tb
SRCS = $(shell cat tb.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | awk '{ print } /^TESTBENCH PASSED$$/ { ok = 1 } END { exit !ok }'

$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert --top-module rs_tb -f tb.f -o Vrs_tb

clean:
	rm -rf obj_dir
